// ==== all.f ====
src/rv_pipe_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_hazard.sv
src/rv_core.sv
test/rv_core_sva.sv
test/tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv_core -Mdir obj_dir -o sim_tb \
    -f all.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
    exit 0
fi
exit 1

// ==== src/rv_alu.sv ====
`timescale 1ns/100ps

module rv_alu import rv_pipe_pkg::*; (
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    equal
);

    logic lt_signed;

    assign lt_signed = $signed(a) < $signed(b);

    // branch decision only looks at this
    assign equal = (a == b);

    always_comb begin
        case (op)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                result = a - b;
            end
            alu_and: begin
                result = a & b;
            end
            alu_or: begin
                result = a | b;
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_slt: begin
                result = {31'b0, lt_signed};
            end
            // lui, immediate already shifted by decode
            alu_pass_b: begin
                result = b;
            end
            default: begin
                result = a + b;
            end
        endcase
    end

endmodule

// ==== src/rv_core.sv ====
`timescale 1ns/100ps

module rv_core import rv_pipe_pkg::*; #(
    parameter word_t reset_vector = 32'h0000_0060
) (
    input  logic  clk,
    input  logic  rst_n,
    output logic  inst_read,
    output word_t inst_addr,
    input  logic  inst_resp,
    input  word_t inst_rdata,
    output logic  data_read,
    output logic  data_write,
    output word_t data_addr,
    output word_t data_wdata,
    input  logic  data_resp,
    input  word_t data_rdata
);

    word_t    pc;
    word_t    id_pc;
    word_t    id_instr;
    decoded_t id_dec;
    ctrl_t    id_ctrl;
    word_t    id_rs1_val;
    word_t    id_rs2_val;
    id_ex_t   id_ex;
    id_ex_t   id_ex_n;
    ex_mem_t  ex_mem;
    ex_mem_t  ex_mem_n;
    mem_wb_t  mem_wb;
    mem_wb_t  mem_wb_n;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    wb_sel_t  wb_sel;
    logic     load_use;
    logic     running;
    logic     data_done;
    word_t    data_buf;
    logic     mem_req;
    logic     freeze;
    logic     redirect;
    logic     alu_equal;
    word_t    mem_fwd;
    word_t    wb_value;
    word_t    op_a;
    word_t    op_b;
    word_t    alu_result;
    word_t    br_target;
    word_t    redirect_pc;

    // fetch request goes up the cycle after reset releases
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    assign inst_read = running;
    assign inst_addr = pc;

    // data port straight off EX/MEM and dropped once answered
    assign mem_req    = ex_mem.ctrl.mem_read | ex_mem.ctrl.mem_write;
    assign data_read  = ex_mem.ctrl.mem_read & ~data_done;
    assign data_write = ex_mem.ctrl.mem_write & ~data_done;
    assign data_addr  = ex_mem.alu_res;
    assign data_wdata = ex_mem.store_data;

    // whole pipe waits on either port
    assign freeze = ~(inst_read & inst_resp) | (mem_req & ~data_done & ~data_resp);

    // remember a data answer while the fetch is still pending
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_done <= 1'b0;
        end else if (!freeze) begin
            data_done <= 1'b0;
        end else if ((data_read | data_write) & data_resp) begin
            data_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (data_read & data_resp) begin
            data_buf <= data_rdata;
        end
    end

    rv_decode u_decode (
        .instr   (id_instr),
        .decoded (id_dec),
        .ctrl    (id_ctrl)
    );

    rv_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (mem_wb.ctrl.reg_write),
        .waddr   (mem_wb.rd),
        .wdata   (wb_value),
        .raddr_a (id_dec.rs1),
        .raddr_b (id_dec.rs2),
        .rdata_a (id_rs1_val),
        .rdata_b (id_rs2_val)
    );

    rv_hazard u_hazard (
        .id_rs1     (id_dec.rs1),
        .id_rs2     (id_dec.rs2),
        .ex_rs1     (id_ex.dec.rs1),
        .ex_rs2     (id_ex.dec.rs2),
        .ex_is_load (id_ex.ctrl.mem_read),
        .ex_rd      (id_ex.dec.rd),
        .mem_rd     (ex_mem.rd),
        .wb_rd      (mem_wb.rd),
        .mem_writes (ex_mem.ctrl.reg_write),
        .wb_writes  (mem_wb.ctrl.reg_write),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .load_use   (load_use)
    );

    // jal in MEM forwards its link rather than the target
    assign mem_fwd = ex_mem.ctrl.jump ? ex_mem.pc + INSTR_STEP : ex_mem.alu_res;

    always_comb begin
        if (mem_wb.ctrl.mem_read) begin
            wb_sel = wb_load;
        end else if (mem_wb.ctrl.jump) begin
            wb_sel = wb_pc4;
        end else begin
            wb_sel = wb_alu;
        end
        case (wb_sel)
            wb_load: wb_value = mem_wb.load_data;
            wb_pc4:  wb_value = mem_wb.pc + INSTR_STEP;
            default: wb_value = mem_wb.alu_res;
        endcase
    end

    // forwarded operands
    always_comb begin
        case (fwd_a)
            fwd_mem: op_a = mem_fwd;
            fwd_wb:  op_a = wb_value;
            default: op_a = id_ex.rs1_val;
        endcase
        case (fwd_b)
            fwd_mem: op_b = mem_fwd;
            fwd_wb:  op_b = wb_value;
            default: op_b = id_ex.rs2_val;
        endcase
    end

    rv_alu u_alu (
        .op     (id_ex.ctrl.alu_op),
        .a      (id_ex.ctrl.alu_src_a_pc ? id_ex.pc : op_a),
        .b      (id_ex.ctrl.alu_src_b_imm ? id_ex.dec.imm : op_b),
        .result (alu_result),
        .equal  (alu_equal)
    );

    // separate target adder since the ALU compares on branches
    assign br_target   = id_ex.pc + id_ex.dec.imm;
    assign redirect    = id_ex.ctrl.jump |
                         (id_ex.ctrl.branch & (alu_equal ^ id_ex.ctrl.branch_ne));
    assign redirect_pc = id_ex.ctrl.jump ? alu_result : br_target;

    always_comb begin
        id_ex_n = '{pc: id_pc, dec: id_dec, ctrl: id_ctrl,
                    rs1_val: id_rs1_val, rs2_val: id_rs2_val};
        // bubble on flush or interlock
        if (redirect | load_use) begin
            id_ex_n = '0;
        end
        ex_mem_n = '{pc: id_ex.pc, rd: id_ex.dec.rd, ctrl: id_ex.ctrl,
                     alu_res: alu_result, store_data: op_b};
        mem_wb_n = '{pc: ex_mem.pc, rd: ex_mem.rd, ctrl: ex_mem.ctrl,
                     alu_res: ex_mem.alu_res,
                     load_data: data_done ? data_buf : data_rdata};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= reset_vector;
            id_pc    <= '0;
            id_instr <= NOP_INSTR;
            id_ex    <= '0;
            ex_mem   <= '0;
            mem_wb   <= '0;
        end else if (!freeze) begin
            id_ex  <= id_ex_n;
            ex_mem <= ex_mem_n;
            mem_wb <= mem_wb_n;
            if (redirect) begin
                // drop the fetched word and refetch at the target
                pc       <= redirect_pc;
                id_pc    <= pc;
                id_instr <= NOP_INSTR;
            end else if (!load_use) begin
                pc       <= pc + INSTR_STEP;
                id_pc    <= pc;
                id_instr <= inst_rdata;
            end
        end
    end

endmodule

// ==== src/rv_decode.sv ====
`timescale 1ns/100ps

module rv_decode import rv_pipe_pkg::*; (
    input  word_t    instr,
    output decoded_t decoded,
    output ctrl_t    ctrl
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    logic       ok;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // immediates of every format, sign extended from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl           = '0;
        ok             = 1'b1;
        decoded.opcode = opcode_t'(instr[6:0]);
        decoded.rs1    = instr[19:15];
        decoded.rs2    = instr[24:20];
        decoded.rd     = instr[11:7];
        decoded.imm    = imm_i;

        case (decoded.opcode)
            op_imm: begin
                // no rs2 in I-type, clear it so no false interlock
                decoded.rs2        = '0;
                ctrl.alu_src_b_imm = 1'b1;
                ctrl.reg_write     = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_op = alu_add;
                    3'b010: ctrl.alu_op = alu_slt;
                    3'b100: ctrl.alu_op = alu_xor;
                    3'b110: ctrl.alu_op = alu_or;
                    3'b111: ctrl.alu_op = alu_and;
                    default: ok = 1'b0;
                endcase
            end
            op_reg: begin
                ctrl.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_op = alu_add;
                    {7'b0100000, 3'b000}: ctrl.alu_op = alu_sub;
                    {7'b0000000, 3'b010}: ctrl.alu_op = alu_slt;
                    {7'b0000000, 3'b100}: ctrl.alu_op = alu_xor;
                    {7'b0000000, 3'b110}: ctrl.alu_op = alu_or;
                    {7'b0000000, 3'b111}: ctrl.alu_op = alu_and;
                    default: ok = 1'b0;
                endcase
            end
            op_lui: begin
                decoded.rs1        = '0;
                decoded.rs2        = '0;
                decoded.imm        = imm_u;
                ctrl.alu_op        = alu_pass_b;
                ctrl.alu_src_b_imm = 1'b1;
                ctrl.reg_write     = 1'b1;
            end
            op_load: begin
                // lw only
                decoded.rs2        = '0;
                ctrl.alu_src_b_imm = 1'b1;
                ctrl.reg_write     = 1'b1;
                ctrl.mem_read      = 1'b1;
                ok                 = (funct3 == 3'b010);
            end
            op_store: begin
                decoded.rd         = '0;
                decoded.imm        = imm_s;
                ctrl.alu_src_b_imm = 1'b1;
                ctrl.mem_write     = 1'b1;
                ok                 = (funct3 == 3'b010);
            end
            op_br: begin
                // compare rs1 and rs2, target is formed in the core
                decoded.rd     = '0;
                decoded.imm    = imm_b;
                ctrl.alu_op    = alu_sub;
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = funct3[0];
                ok             = (funct3[2:1] == 2'b00);
            end
            op_jal: begin
                decoded.rs1        = '0;
                decoded.rs2        = '0;
                decoded.imm        = imm_j;
                ctrl.alu_src_a_pc  = 1'b1;
                ctrl.alu_src_b_imm = 1'b1;
                ctrl.reg_write     = 1'b1;
                ctrl.jump          = 1'b1;
            end
            default: ok = 1'b0;
        endcase

        // anything else runs as a no-op
        if (!ok) begin
            ctrl        = '0;
            decoded.rs1 = '0;
            decoded.rs2 = '0;
            decoded.rd  = '0;
        end
    end

endmodule

// ==== src/rv_hazard.sv ====
`timescale 1ns/100ps

module rv_hazard import rv_pipe_pkg::*; (
    input  reg_idx_t id_rs1,
    input  reg_idx_t id_rs2,
    input  reg_idx_t ex_rs1,
    input  reg_idx_t ex_rs2,
    input  logic     ex_is_load,
    input  reg_idx_t ex_rd,
    input  reg_idx_t mem_rd,
    input  reg_idx_t wb_rd,
    input  logic     mem_writes,
    input  logic     wb_writes,
    output fwd_sel_t fwd_a,
    output fwd_sel_t fwd_b,
    output logic     load_use
);

    logic mem_live;
    logic wb_live;

    // x0 results are never forwarded
    assign mem_live = mem_writes && (mem_rd != '0);
    assign wb_live  = wb_writes && (wb_rd != '0);

    // younger result in EX/MEM beats MEM/WB
    function automatic fwd_sel_t pick_src(
        input reg_idx_t rs,
        input logic     m_live,
        input reg_idx_t m_rd,
        input logic     w_live,
        input reg_idx_t w_rd
    );
        fwd_sel_t sel;
        sel = fwd_rf;
        if (w_live && w_rd == rs) begin
            sel = fwd_wb;
        end
        if (m_live && m_rd == rs) begin
            sel = fwd_mem;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = pick_src(ex_rs1, mem_live, mem_rd, wb_live, wb_rd);
        fwd_b = pick_src(ex_rs2, mem_live, mem_rd, wb_live, wb_rd);
    end

    // load data shows up one stage too late for the next instruction
    // check both sources here
    assign load_use = ex_is_load && (ex_rd != '0) &&
                      ((ex_rd == id_rs1) || (ex_rd == id_rs2));

endmodule

// ==== src/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_lui   = 7'b0110111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_br    = 7'b1100011,
        op_jal   = 7'b1101111
    } opcode_t;

    // alu_add must stay at zero so an all-zero control word is a bubble
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_t;

    // EX operand source
    typedef enum logic [1:0] {
        fwd_rf,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

    // writeback source
    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_pc4
    } wb_sel_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src_a_pc;
        logic    alu_src_b_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    branch_ne;
        logic    jump;
    } ctrl_t;

    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
    } decoded_t;

    typedef struct packed {
        word_t    pc;
        decoded_t dec;
        ctrl_t    ctrl;
        word_t    rs1_val;
        word_t    rs2_val;
    } id_ex_t;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        ctrl_t    ctrl;
        word_t    alu_res;
        word_t    store_data;
    } ex_mem_t;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        ctrl_t    ctrl;
        word_t    alu_res;
        word_t    load_data;
    } mem_wb_t;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR  = 32'h0000_0013;
    localparam word_t INSTR_STEP = 32'd4;

endpackage

// ==== src/rv_regfile.sv ====
`timescale 1ns/100ps

module rv_regfile import rv_pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr_a,
    input  reg_idx_t raddr_b,
    output word_t    rdata_a,
    output word_t    rdata_b
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle write is passed straight to the reader
    always_comb begin
        rdata_a = '0;
        rdata_b = '0;
        if (raddr_a != '0) begin
            rdata_a = (we && waddr == raddr_a) ? wdata : regs[raddr_a];
        end
        if (raddr_b != '0) begin
            rdata_b = (we && waddr == raddr_b) ? wdata : regs[raddr_b];
        end
    end

endmodule

// ==== test/rv_core_sva.sv ====
`timescale 1ns/100ps

module rv_core_sva (
    input logic        clk,
    input logic        rst_n,
    input logic        inst_read,
    input logic [31:0] inst_addr,
    input logic        data_read,
    input logic        data_write,
    input logic [31:0] data_addr,
    input logic [31:0] data_wdata,
    input logic        data_resp
);

    // one direction at a time on the data port
    a_no_rw: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_read && data_write))
        else $error("data_read and data_write high together");

    // quiet ports in reset
    a_reset_idle: assert property (@(posedge clk)
        !rst_n |-> (!inst_read && !data_read && !data_write))
        else $error("request high during reset");

    // request held until answered
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ((data_read || data_write) && !data_resp) |=>
        ($stable(data_read) && $stable(data_write) &&
         $stable(data_addr) && $stable(data_wdata)))
        else $error("data request changed while waiting");

    a_inst_align: assert property (@(posedge clk) disable iff (!rst_n)
        inst_read |-> (inst_addr[1:0] == 2'b00))
        else $error("inst_addr not word aligned");

    a_data_align: assert property (@(posedge clk) disable iff (!rst_n)
        (data_read || data_write) |-> (data_addr[1:0] == 2'b00))
        else $error("data_addr not word aligned");

endmodule

// ==== test/tb_rv_core.sv ====
`timescale 1ns/100ps

module tb_rv_core;

    localparam logic [31:0] RESET_VECTOR = 32'h0000_0060;

    logic        clk;
    logic        rst_n;
    logic        inst_read;
    logic [31:0] inst_addr;
    logic        inst_resp;
    logic [31:0] inst_rdata;
    logic        data_read;
    logic        data_write;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic        data_resp;
    logic [31:0] data_rdata;

    // both memories word indexed by addr[9:2]
    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] exp_addr [0:31];
    logic [31:0] exp_data [0:31];
    int          n_exp;
    int          n_instr;
    int          store_idx;
    int          cycles;
    int          limit;
    int          value_errs;
    int          range_errs;
    int          other_errs;
    logic [1:0]  inst_wait;
    logic [1:0]  data_wait;
    logic        timed_out;

    rv_core #(.reset_vector(RESET_VECTOR)) dut (.*);

    bind rv_core rv_core_sva u_sva (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // RV32I encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'h37};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic put(input logic [31:0] instr);
        imem[RESET_VECTOR[9:2] + n_instr] = instr;
        n_instr++;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr[n_exp] = addr;
        exp_data[n_exp] = data;
        n_exp++;
    endtask

    task automatic load_program();
        // dependent ALU chain starting from x1 = 5
        put(i_type(12'd5, 5'd0, 3'd0, 5'd1, 7'h13));
        put(i_type(12'd7, 5'd1, 3'd0, 5'd2, 7'h13));
        put(r_type(7'h00, 5'd1, 5'd2, 3'd0, 5'd3));
        put(r_type(7'h20, 5'd1, 5'd3, 3'd0, 5'd4));
        put(r_type(7'h00, 5'd1, 5'd4, 3'd6, 5'd5));
        put(r_type(7'h00, 5'd2, 5'd5, 3'd7, 5'd6));
        put(r_type(7'h00, 5'd3, 5'd6, 3'd4, 5'd7));
        put(s_type(12'h200, 5'd7, 5'd0));
        put(r_type(7'h00, 5'd7, 5'd1, 3'd2, 5'd8));
        put(s_type(12'h204, 5'd3, 5'd0));
        put(s_type(12'h208, 5'd8, 5'd0));
        put(r_type(7'h20, 5'd7, 5'd1, 3'd0, 5'd11));
        put(i_type(-12'sd3, 5'd0, 3'd0, 5'd9, 7'h13));
        put(r_type(7'h00, 5'd1, 5'd9, 3'd2, 5'd10));
        put(s_type(12'h20c, 5'd11, 5'd0));
        put(s_type(12'h210, 5'd10, 5'd0));
        // immediate forms
        put(i_type(12'hf, 5'd7, 3'd7, 5'd12, 7'h13));
        put(i_type(12'h30, 5'd12, 3'd6, 5'd13, 7'h13));
        put(i_type(12'hfff, 5'd13, 3'd4, 5'd14, 7'h13));
        put(i_type(12'h0, 5'd14, 3'd2, 5'd15, 7'h13));
        put(s_type(12'h214, 5'd14, 5'd0));
        put(s_type(12'h218, 5'd15, 5'd0));
        put(s_type(12'h21c, 5'd5, 5'd0));
        put(s_type(12'h220, 5'd6, 5'd0));
        // lui plus addi
        put(u_type(20'h12345, 5'd16));
        put(i_type(12'h678, 5'd16, 3'd0, 5'd16, 7'h13));
        put(s_type(12'h224, 5'd16, 5'd0));
        put(u_type(20'hdeadc, 5'd17));
        put(i_type(-12'sd273, 5'd17, 3'd0, 5'd17, 7'h13));
        put(s_type(12'h228, 5'd17, 5'd0));
        // load-use on rs1, rs2 and store data
        put(i_type(12'h100, 5'd0, 3'd2, 5'd18, 7'h03));
        put(r_type(7'h00, 5'd1, 5'd18, 3'd0, 5'd19));
        put(i_type(12'h104, 5'd0, 3'd2, 5'd20, 7'h03));
        put(r_type(7'h00, 5'd20, 5'd1, 3'd0, 5'd21));
        put(s_type(12'h22c, 5'd19, 5'd0));
        put(s_type(12'h230, 5'd21, 5'd0));
        put(i_type(12'h100, 5'd0, 3'd2, 5'd22, 7'h03));
        put(s_type(12'h234, 5'd22, 5'd0));
        // control flow with poison stores at 0x3f0 and 0x3f4
        put(b_type(13'd8, 5'd4, 5'd2, 3'd0));
        put(s_type(12'h3f0, 5'd1, 5'd0));
        put(b_type(13'd8, 5'd4, 5'd2, 3'd1));
        put(s_type(12'h238, 5'd2, 5'd0));
        put(j_type(21'd8, 5'd23));
        put(s_type(12'h3f4, 5'd1, 5'd0));
        put(s_type(12'h23c, 5'd23, 5'd0));
        // x0 stays zero
        put(i_type(12'd99, 5'd0, 3'd0, 5'd0, 7'h13));
        put(s_type(12'h240, 5'd0, 5'd0));
        // park here
        put(j_type(21'd0, 5'd0));
    endtask

    task automatic build_expected();
        expect_store(32'h200, 32'd29);
        expect_store(32'h204, 32'd17);
        expect_store(32'h208, 32'd1);
        expect_store(32'h20c, 32'hffff_ffe8);
        expect_store(32'h210, 32'd1);
        expect_store(32'h214, 32'hffff_ffc2);
        expect_store(32'h218, 32'd1);
        expect_store(32'h21c, 32'd13);
        expect_store(32'h220, 32'd12);
        expect_store(32'h224, 32'h1234_5678);
        expect_store(32'h228, 32'hdead_beef);
        expect_store(32'h22c, 32'h0000_1239);
        expect_store(32'h230, 32'hffff_fff5);
        expect_store(32'h234, 32'h0000_1234);
        expect_store(32'h238, 32'd12);
        // link is the word after the jal at program word 42
        expect_store(32'h23c, RESET_VECTOR + 32'd43 * 4);
        expect_store(32'h240, 32'd0);
    endtask

    // memory models answer in 1 to 4 cycles
    always @(posedge clk) begin
        if (!rst_n) begin
            inst_resp <= 1'b0;
            data_resp <= 1'b0;
            inst_wait <= '0;
            data_wait <= '0;
        end else begin
            if (inst_resp) begin
                inst_resp <= 1'b0;
                inst_wait <= 2'($urandom % 4);
            end else if (inst_read) begin
                if (inst_wait == 0) begin
                    inst_resp  <= 1'b1;
                    inst_rdata <= imem[inst_addr[9:2]];
                end else begin
                    inst_wait <= inst_wait - 1'b1;
                end
            end
            if (data_resp) begin
                data_resp <= 1'b0;
                data_wait <= 2'($urandom % 4);
                if (data_write) begin
                    dmem[data_addr[9:2]] <= data_wdata;
                end
            end else if (data_read || data_write) begin
                if (data_wait == 0) begin
                    data_resp  <= 1'b1;
                    data_rdata <= dmem[data_addr[9:2]];
                end else begin
                    data_wait <= data_wait - 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rst_n && data_write && data_resp) begin
            store_idx <= store_idx + 1;
        end
    end

    a_in_table: assert property (@(posedge clk) disable iff (!rst_n)
        (data_write && data_resp) |-> (store_idx < n_exp))
        else begin
            range_errs++;
            $display("store to %h beyond the expected table", $sampled(data_addr));
        end

    a_store_addr: assert property (@(posedge clk) disable iff (!rst_n)
        (data_write && data_resp && store_idx < n_exp) |-> (data_addr == exp_addr[store_idx]))
        else begin
            value_errs++;
            $display("[ERROR] data_addr got %h expected %h", $sampled(data_addr),
                     exp_addr[$sampled(store_idx)]);
        end

    a_store_data: assert property (@(posedge clk) disable iff (!rst_n)
        (data_write && data_resp && store_idx < n_exp) |-> (data_wdata == exp_data[store_idx]))
        else begin
            value_errs++;
            $display("[ERROR] data_wdata got %h expected %h", $sampled(data_wdata),
                     exp_data[$sampled(store_idx)]);
        end

    initial begin
        void'($urandom(52));
        rst_n      = 1'b0;
        inst_resp  = 1'b0;
        inst_rdata = '0;
        data_resp  = 1'b0;
        data_rdata = '0;
        n_exp      = 0;
        n_instr    = 0;
        store_idx  = 0;
        cycles     = 0;
        value_errs = 0;
        range_errs = 0;
        other_errs = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0000_0013;
            dmem[i] = 32'hc0de_0000 | (i << 2);
        end
        dmem[32'h100 >> 2] = 32'h0000_1234;
        dmem[32'h104 >> 2] = 32'hffff_fff0;
        load_program();
        build_expected();
        limit = 40 * n_instr;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        while (store_idx < n_exp && cycles < limit) begin
            @(posedge clk);
        end
        timed_out = (store_idx < n_exp);
        // catch late extra stores
        repeat (20) @(posedge clk);

        a_count: assert (store_idx == n_exp)
            else begin
                other_errs++;
                $display("store count %0d does not match table length %0d", store_idx, n_exp);
            end
        if (timed_out) begin
            other_errs++;
            $display("timeout after %0d cycles", cycles);
        end
        $display("errors: value %0d, range %0d, other %0d", value_errs, range_errs, other_errs);
        if (value_errs + range_errs + other_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
